// File: filelist.f
+incdir+include
verilog/da_pkg.sv
verilog/report_req_if.sv
verilog/packet_parser.sv
verilog/echo_buffer.sv
verilog/report_framer.sv
verilog/da_host_core.sv
verification/tb_da_host_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the host engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_da_host_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

output=$(./obj_dir/Vtb_da_host_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verification/tb_da_host_core.sv
// ##################################################
// Host packet engine testbench
// Sends command packets, models the expected reports
// and control strobes, checks them with assertions
// ##################################################

`timescale 1ns/100ps
`include "da_macros.svh"

module tb_da_host_core import da_pkg::*; ();

    localparam int NUM_TESTS       = 16;
    localparam int CYCLES_PER_TEST = 200;
    localparam int CLK_PERIOD      = 10;

    logic                          clk_core = 1'b0;
    logic                          reset;
    logic                          host_in_valid;
    logic [`HOST_W-1:0]            host_in_data;
    logic [7:0]                    status_in;
    logic                          host_out_valid;
    logic [`HOST_W-1:0]            host_out_data;
    logic                          ctl_valid;
    logic [$clog2(`NUM_SLOTS)-1:0] ctl_slot;
    logic [7:0]                    ctl_data;
    logic                          busy;

    // Driver side of the model
    logic [`HOST_W-1:0]            rep_q[$];
    logic [`HOST_W-1:0]            pay_q[$];
    int                            rep_go_cyc = -1;
    logic                          drv_ctl = 1'b0;
    logic [$clog2(`NUM_SLOTS)-1:0] drv_ctl_slot = '0;
    logic [7:0]                    drv_ctl_data = '0;
    // Cycle-aligned expected outputs
    int                            cyc = 0;
    int                            rd_idx = 0;
    logic                          streaming = 1'b0;
    logic                          exp_valid = 1'b0;
    logic [`HOST_W-1:0]            exp_data = '0;
    logic                          exp_ctl_valid = 1'b0;
    logic [$clog2(`NUM_SLOTS)-1:0] exp_ctl_slot = '0;
    logic [7:0]                    exp_ctl_data = '0;
    // Bookkeeping
    logic [31:0]                   seed = 32'hde58_027b;
    int                            assert_errs = 0;
    int                            drv_errs = 0;
    int                            errs_seen = 0;
    int                            test_num = 0;
    int                            failed_tests = 0;
    int                            total_errs;

    always #(CLK_PERIOD / 2) clk_core = ~clk_core;

    da_host_core dut (
        .clk_core       (clk_core),
        .reset          (reset),
        .host_in_valid  (host_in_valid),
        .host_in_data   (host_in_data),
        .status_in      (status_in),
        .host_out_valid (host_out_valid),
        .host_out_data  (host_out_data),
        .ctl_valid      (ctl_valid),
        .ctl_slot       (ctl_slot),
        .ctl_data       (ctl_data),
        .busy           (busy)
    );

    // Report streams out back to back from the second edge after its last input word
    always @(posedge clk_core) begin
        if (cyc == rep_go_cyc)
            streaming = 1'b1;
        if (streaming && rd_idx < rep_q.size()) begin
            exp_valid <= 1'b1;
            exp_data  <= rep_q[rd_idx];
            rd_idx = rd_idx + 1;
        end else begin
            exp_valid <= 1'b0;
            streaming = 1'b0;
        end
        // Control strobe one cycle after its data word
        exp_ctl_valid <= drv_ctl;
        exp_ctl_slot  <= drv_ctl_slot;
        exp_ctl_data  <= drv_ctl_data;
        cyc = cyc + 1;
    end

    task automatic flag_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        assert_errs++;
    endtask

    a_out_valid: assert property (@(posedge clk_core) disable iff (reset)
        host_out_valid == exp_valid)
        else flag_error($sformatf("host_out_valid %b, expected %b",
            $sampled(host_out_valid), $sampled(exp_valid)));

    a_out_data: assert property (@(posedge clk_core) disable iff (reset)
        host_out_valid |-> host_out_data == exp_data)
        else flag_error($sformatf("host_out_data %h, expected %h",
            $sampled(host_out_data), $sampled(exp_data)));

    // Busy spans exactly the report words
    a_busy: assert property (@(posedge clk_core) disable iff (reset)
        busy == exp_valid)
        else flag_error($sformatf("busy %b, expected %b", $sampled(busy), $sampled(exp_valid)));

    a_ctl_valid: assert property (@(posedge clk_core) disable iff (reset)
        ctl_valid == exp_ctl_valid)
        else flag_error($sformatf("ctl_valid %b, expected %b",
            $sampled(ctl_valid), $sampled(exp_ctl_valid)));

    a_ctl_fields: assert property (@(posedge clk_core) disable iff (reset)
        ctl_valid |-> (ctl_slot == exp_ctl_slot && ctl_data == exp_ctl_data))
        else flag_error($sformatf("ctl slot/data %h/%h, expected %h/%h",
            $sampled(ctl_slot), $sampled(ctl_data),
            $sampled(exp_ctl_slot), $sampled(exp_ctl_data)));

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic drive_word(input logic [`HOST_W-1:0] word);
        @(negedge clk_core);
        host_in_valid = 1'b1;
        host_in_data  = word;
        drv_ctl       = 1'b0;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_core);
            host_in_valid = 1'b0;
            host_in_data  = '0;
            drv_ctl       = 1'b0;
        end
    endtask

    // Header, queued payload and footer sum of one report
    task automatic queue_report(input logic [7:0] slot, input report_e code);
        logic [`CKSUM_W-1:0] sum;
        logic [`LEN_W-1:0]   len;
        logic [`HOST_W-1:0]  hdr[4];
        len    = `LEN_W'(pay_q.size());
        hdr[0] = {8'h00, slot};
        hdr[1] = {8'h00, code};
        hdr[2] = {8'h00, len[23:16]};
        hdr[3] = len[15:0];
        sum    = '0;
        foreach (hdr[i]) begin
            rep_q.push_back(hdr[i]);
            sum = sum + {16'h0000, hdr[i]};
        end
        foreach (pay_q[i]) begin
            rep_q.push_back(pay_q[i]);
            sum = sum + {16'h0000, pay_q[i]};
        end
        rep_q.push_back(sum[31:16]);
        rep_q.push_back(sum[15:0]);
        pay_q.delete();
        rep_go_cyc = cyc + 1;
    endtask

    task automatic wait_report();
        int n;
        drive_idle(1);
        n = 0;
        while ((rd_idx < rep_q.size() || exp_valid || busy) && n < 100) begin
            @(negedge clk_core);
            n++;
        end
        if (n >= 100) begin
            $display("Report was still going after 100 cycles");
            drv_errs++;
        end
    endtask

    task automatic send_status();
        logic [31:0] r;
        r = rand_next();
        drive_word({8'h00, r[7:0]});
        status_in = r[15:8];
        drive_word({8'h00, STATUS_READ});
        pay_q.push_back({8'h00, r[15:8]});
        queue_report(`GLOBAL_TARGET, STATUS_REPORT);
        wait_report();
    endtask

    task automatic send_echo(input int count);
        logic [31:0] r;
        logic [7:0]  target;
        r      = rand_next();
        target = r[7:0];
        drive_word({8'h00, target});
        drive_word({8'h00, ECHO_SEND});
        drive_word(`HOST_W'(count));
        repeat (count) begin
            r = rand_next();
            drive_word(r[31:16]);
            pay_q.push_back(r[31:16]);
        end
        queue_report(target, ECHO_REPORT);
        wait_report();
    endtask

    // Corrupt flips at least one checksum bit
    task automatic send_write(input bit corrupt);
        logic [31:0]         r;
        logic [7:0]          target;
        logic [`LEN_W-1:0]   len;
        logic [`CKSUM_W-1:0] sum;
        logic [`CKSUM_W-1:0] ck;
        r      = rand_next();
        target = {5'd0, r[2:0]};
        len    = `LEN_W'(r[10:8]) + 1'b1;
        sum    = '0;
        drive_word({8'h00, target});
        drive_word({8'h00, CMD_FIFO_WRITE});
        drive_word({8'h00, len[23:16]});
        drive_word(len[15:0]);
        repeat (int'(len)) begin
            r = rand_next();
            drive_word(r[31:16]);
            drv_ctl      = (int'(target) < `NUM_SLOTS);
            drv_ctl_slot = target[$clog2(`NUM_SLOTS)-1:0];
            drv_ctl_data = r[23:16];
            sum          = sum + {16'h0000, r[31:16]};
        end
        r  = rand_next();
        ck = corrupt ? (sum ^ {r[31:1], 1'b1}) : sum;
        drive_word(ck[31:16]);
        drive_word(ck[15:0]);
        if (corrupt) begin
            pay_q.push_back(ck[31:16]);
            pay_q.push_back(ck[15:0]);
            pay_q.push_back(sum[31:16]);
            pay_q.push_back(sum[15:0]);
            queue_report(target, CHECKSUM_ERROR);
            wait_report();
        end else begin
            drive_idle(4);
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = assert_errs + drv_errs;
        test_num++;
        if (errs == errs_seen) begin
            $display("Test %0d %s: ok", test_num, name);
        end else begin
            $display("Test %0d %s: %0d error(s)", test_num, name, errs - errs_seen);
            failed_tests++;
        end
        errs_seen = errs;
    endtask

    initial begin
        reset         = 1'b1;
        host_in_valid = 1'b0;
        host_in_data  = '0;
        status_in     = '0;
        repeat (2) @(posedge clk_core);
        @(negedge clk_core);
        reset = 1'b0;

        drive_idle(10);
        end_test("idle after reset");
        repeat (3) begin
            send_status();
            end_test("status read");
        end
        send_echo(1);
        end_test("echo of 1 word");
        send_echo(`ECHO_DEPTH);
        end_test("echo of full depth");
        repeat (3) begin
            send_echo(int'(rand_next() % 32'd16) + 1);
            end_test("echo of random length");
        end
        repeat (3) begin
            send_write(1'b0);
            end_test("control write");
        end
        repeat (3) begin
            send_write(1'b1);
            end_test("control write with bad checksum");
        end
        // Unknown opcode, then a normal status read
        drive_word(16'h0003);
        drive_word(16'h0055);
        drive_idle(4);
        send_status();
        end_test("unknown opcode");

        drive_idle(4);
        total_errs = assert_errs + drv_errs;
        $display("Tests: %0d, failed: %0d, errors: %0d", test_num, failed_tests, total_errs);
        if (total_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD + 1000);
        $display("Watchdog expired before all tests completed");
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: verilog/da_host_core.sv
// ################################################
// Host packet engine top level
// Parser, echo buffer and report framer
// ################################################

`timescale 1ns/100ps
`include "da_macros.svh"

module da_host_core (
    input  logic                          clk_core,
    input  logic                          reset,
    input  logic                          host_in_valid,
    input  logic [`HOST_W-1:0]            host_in_data,
    input  logic [7:0]                    status_in,
    output logic                          host_out_valid,
    output logic [`HOST_W-1:0]            host_out_data,
    output logic                          ctl_valid,
    output logic [$clog2(`NUM_SLOTS)-1:0] ctl_slot,
    output logic [7:0]                    ctl_data,
    output logic                          busy
);

    // Echo path between the stages
    logic               echo_push;
    logic [`HOST_W-1:0] echo_push_data;
    logic               echo_pop;
    logic [`HOST_W-1:0] echo_pop_data;
    logic               echo_empty;

    report_req_if req_bus ();

    packet_parser parser (
        .clk_core      (clk_core),
        .reset         (reset),
        .host_in_valid (host_in_valid),
        .host_in_data  (host_in_data),
        .status_in     (status_in),
        .ctl_valid     (ctl_valid),
        .ctl_slot      (ctl_slot),
        .ctl_data      (ctl_data),
        .echo_push     (echo_push),
        .echo_data     (echo_push_data),
        .req           (req_bus.parser)
    );

    echo_buffer #(.DEPTH(`ECHO_DEPTH)) echo_fifo (
        .clk_core  (clk_core),
        .reset     (reset),
        .push      (echo_push),
        .push_data (echo_push_data),
        .pop       (echo_pop),
        .pop_data  (echo_pop_data),
        .empty     (echo_empty)
    );

    report_framer framer (
        .clk_core       (clk_core),
        .reset          (reset),
        .req            (req_bus.framer),
        .echo_data      (echo_pop_data),
        .echo_empty     (echo_empty),
        .echo_pop       (echo_pop),
        .host_out_valid (host_out_valid),
        .host_out_data  (host_out_data)
    );

    // Host must hold off new packets while high
    assign busy = req_bus.busy;

endmodule

// File: verilog/report_framer.sv
// ################################################
// Report framer, stage 2
// Sends header, payload and running-sum footer
// ################################################

`timescale 1ns/100ps
`include "da_macros.svh"

module report_framer import da_pkg::*; (
    input  logic               clk_core,
    input  logic               reset,
    report_req_if.framer       req,
    input  logic [`HOST_W-1:0] echo_data,
    input  logic               echo_empty,
    output logic               echo_pop,
    output logic               host_out_valid,
    output logic [`HOST_W-1:0] host_out_data
);

    framer_state_e        state;
    // Word index inside the current section
    logic [`LEN_W-1:0]    cnt;
    report_e              kind_q;
    logic [`LEN_W-1:0]    len_q;
    logic [`CKSUM_W-1:0]  ck_rx_q;
    logic [`CKSUM_W-1:0]  ck_calc_q;
    // Sum of header and payload words sent so far
    logic [`CKSUM_W-1:0]  sum;
    logic [`HOST_W-1:0]   word_next;

    // Word to send on the next cycle
    always_comb begin
        word_next = '0;
        echo_pop  = 1'b0;
        case (state)
            F_IDLE: word_next = `HOST_W'(req.slot);
            F_HEADER: begin
                case (cnt[1:0])
                    2'd1:    word_next = `HOST_W'(kind_q);
                    2'd2:    word_next = `HOST_W'(len_q[`LEN_W-1:`HOST_W]);
                    default: word_next = len_q[`HOST_W-1:0];
                endcase
            end
            F_PAYLOAD: begin
                case (kind_q)
                    ECHO_REPORT: begin
                        word_next = echo_data;
                        echo_pop  = !echo_empty;
                    end
                    // Received value first, then calculated
                    CHECKSUM_ERROR: begin
                        case (cnt[1:0])
                            2'd0:    word_next = ck_rx_q[31:16];
                            2'd1:    word_next = ck_rx_q[15:0];
                            2'd2:    word_next = ck_calc_q[31:16];
                            default: word_next = ck_calc_q[15:0];
                        endcase
                    end
                    default: word_next = ck_rx_q[15:0];
                endcase
            end
            // Footer high word first
            F_FOOTER: word_next = cnt[0] ? sum[15:0] : sum[31:16];
            default: word_next = '0;
        endcase
    end

    always_ff @(posedge clk_core) begin
        if (reset) begin
            state          <= F_IDLE;
            cnt            <= '0;
            req.busy       <= 1'b0;
            host_out_valid <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    host_out_valid <= req.start;
                    req.busy       <= req.start;
                    if (req.start) begin
                        // Slot word goes out now
                        cnt   <= `LEN_W'(1);
                        state <= F_HEADER;
                    end
                end
                F_HEADER: begin
                    host_out_valid <= 1'b1;
                    if (cnt == `LEN_W'(3)) begin
                        cnt   <= '0;
                        state <= (len_q == '0) ? F_FOOTER : F_PAYLOAD;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                F_PAYLOAD: begin
                    host_out_valid <= 1'b1;
                    if (cnt == len_q - 1'b1) begin
                        cnt   <= '0;
                        state <= F_FOOTER;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                F_FOOTER: begin
                    host_out_valid <= 1'b1;
                    cnt            <= cnt + 1'b1;
                    // Busy drops with valid after the last word
                    if (cnt[0])
                        state <= F_IDLE;
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_core) begin
        host_out_data <= word_next;
        if (state == F_IDLE && req.start) begin
            kind_q    <= req.kind;
            len_q     <= req.length;
            ck_rx_q   <= req.ck_rx;
            ck_calc_q <= req.ck_calc;
            sum       <= `CKSUM_W'(word_next);
        end else if (state == F_HEADER || state == F_PAYLOAD) begin
            sum <= sum + `CKSUM_W'(word_next);
        end
    end

endmodule

// File: verilog/echo_buffer.sv
// ################################################
// Echo payload FIFO, first word falls through
// ################################################

`timescale 1ns/100ps
`include "da_macros.svh"

module echo_buffer #(
    parameter int DEPTH = 16
) (
    input  logic               clk_core,
    input  logic               reset,
    input  logic               push,
    input  logic [`HOST_W-1:0] push_data,
    input  logic               pop,
    output logic [`HOST_W-1:0] pop_data,
    output logic               empty
);

    localparam int AW = $clog2(DEPTH);

    logic [`HOST_W-1:0] mem [DEPTH];
    // Extra top bit tells a full wrap from empty
    logic [AW:0]        wr_ptr;
    logic [AW:0]        rd_ptr;

    always_ff @(posedge clk_core) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (push)
            mem[wr_ptr[AW-1:0]] <= push_data;
    end

    // Head word visible without a read cycle
    assign pop_data = mem[rd_ptr[AW-1:0]];
    assign empty    = (wr_ptr == rd_ptr);

endmodule

// File: verilog/packet_parser.sv
// ################################################
// Host packet parser, stage 1
// Decodes commands, forwards control bytes, pushes
// echo data and requests reports from the framer
// ################################################

`timescale 1ns/100ps
`include "da_macros.svh"

module packet_parser import da_pkg::*; (
    input  logic                          clk_core,
    input  logic                          reset,
    input  logic                          host_in_valid,
    input  logic [`HOST_W-1:0]            host_in_data,
    input  logic [7:0]                    status_in,
    output logic                          ctl_valid,
    output logic [$clog2(`NUM_SLOTS)-1:0] ctl_slot,
    output logic [7:0]                    ctl_data,
    output logic                          echo_push,
    output logic [`HOST_W-1:0]            echo_data,
    report_req_if.parser                  req
);

    localparam int ECHO_W = $clog2(`ECHO_DEPTH) + 1;
    localparam int LEN_HI_W = `LEN_W - `HOST_W;

    parser_state_e          state;
    opcode_e                opcode;
    logic                   accept;
    // Words left in the echo or write data section
    logic [`LEN_W-1:0]      word_cnt;
    logic [7:0]             target;
    logic [ECHO_W-1:0]      echo_len;
    logic [LEN_HI_W-1:0]    len_hi;
    logic [`HOST_W-1:0]     ck_hi;
    // Sum of write data words
    logic [`CKSUM_W-1:0]    sum;

    // Words seen while a report goes out are dropped
    assign accept = host_in_valid && !req.busy;
    assign opcode = opcode_e'(host_in_data[7:0]);

    always_ff @(posedge clk_core) begin
        if (reset) begin
            state     <= P_TARGET;
            word_cnt  <= '0;
            req.start <= 1'b0;
            echo_push <= 1'b0;
            ctl_valid <= 1'b0;
        end else begin
            req.start <= 1'b0;
            echo_push <= 1'b0;
            ctl_valid <= 1'b0;
            if (accept) begin
                case (state)
                    P_TARGET: state <= P_OPCODE;
                    P_OPCODE: begin
                        case (opcode)
                            STATUS_READ: begin
                                req.start <= 1'b1;
                                state     <= P_TARGET;
                            end
                            ECHO_SEND:      state <= P_ECHO_COUNT;
                            CMD_FIFO_WRITE: state <= P_LEN_HI;
                            // Unknown opcode, wait for the next packet
                            default:        state <= P_TARGET;
                        endcase
                    end
                    P_ECHO_COUNT: begin
                        // Counts outside 1..depth are ignored
                        if (host_in_data != '0 && host_in_data <= `ECHO_DEPTH) begin
                            word_cnt <= `LEN_W'(host_in_data);
                            state    <= P_ECHO_DATA;
                        end else begin
                            state <= P_TARGET;
                        end
                    end
                    P_ECHO_DATA: begin
                        echo_push <= 1'b1;
                        word_cnt  <= word_cnt - 1'b1;
                        if (word_cnt == `LEN_W'(1)) begin
                            req.start <= 1'b1;
                            state     <= P_TARGET;
                        end
                    end
                    P_LEN_HI: state <= P_LEN_LO;
                    P_LEN_LO: begin
                        word_cnt <= {len_hi, host_in_data};
                        // Zero length goes straight to the checksum
                        if ({len_hi, host_in_data} == '0)
                            state <= P_CK_HI;
                        else
                            state <= P_WR_DATA;
                    end
                    P_WR_DATA: begin
                        ctl_valid <= (target < `NUM_SLOTS);
                        word_cnt  <= word_cnt - 1'b1;
                        if (word_cnt == `LEN_W'(1))
                            state <= P_CK_HI;
                    end
                    P_CK_HI: state <= P_CK_LO;
                    P_CK_LO: begin
                        // Report only on a mismatch
                        req.start <= ({ck_hi, host_in_data} != sum);
                        state     <= P_TARGET;
                    end
                    default: state <= P_TARGET;
                endcase
            end
        end
    end

    // Packet fields and request payload
    always_ff @(posedge clk_core) begin
        if (accept) begin
            case (state)
                P_TARGET: target <= host_in_data[7:0];
                P_OPCODE: begin
                    sum        <= '0;
                    req.kind   <= STATUS_REPORT;
                    req.slot   <= `GLOBAL_TARGET;
                    req.length <= `LEN_W'(1);
                    // Status byte rides in ck_rx as the payload
                    req.ck_rx  <= `CKSUM_W'(status_in);
                end
                P_ECHO_COUNT: echo_len <= host_in_data[ECHO_W-1:0];
                P_ECHO_DATA: begin
                    echo_data  <= host_in_data;
                    req.kind   <= ECHO_REPORT;
                    req.slot   <= target;
                    req.length <= `LEN_W'(echo_len);
                end
                P_LEN_HI: len_hi <= host_in_data[LEN_HI_W-1:0];
                P_WR_DATA: begin
                    ctl_slot <= target[$clog2(`NUM_SLOTS)-1:0];
                    // Control protocol carries the low byte only
                    ctl_data <= host_in_data[7:0];
                    sum      <= sum + `CKSUM_W'(host_in_data);
                end
                P_CK_HI: ck_hi <= host_in_data;
                P_CK_LO: begin
                    req.kind    <= CHECKSUM_ERROR;
                    req.slot    <= target;
                    req.length  <= `LEN_W'(4);
                    req.ck_rx   <= {ck_hi, host_in_data};
                    req.ck_calc <= sum;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: verilog/report_req_if.sv
// ################################################
// Report request from parser to framer
// ################################################

`timescale 1ns/100ps
`include "da_macros.svh"

interface report_req_if import da_pkg::*; ();

    // One-cycle request strobe and its fields
    logic                 start;
    report_e              kind;
    logic [7:0]           slot;
    logic [`LEN_W-1:0]    length;
    // Status value or received checksum
    logic [`CKSUM_W-1:0]  ck_rx;
    logic [`CKSUM_W-1:0]  ck_calc;
    // Report in progress, parser holds off
    logic                 busy;

    modport parser (
        output start, kind, slot, length, ck_rx, ck_calc,
        input  busy
    );

    modport framer (
        input  start, kind, slot, length, ck_rx, ck_calc,
        output busy
    );

endinterface

// File: verilog/da_pkg.sv
// ################################################
// Host engine package
// Command opcodes, report codes and FSM states
// ################################################

package da_pkg;

    // Command opcodes, low byte of the command word
    typedef enum logic [7:0] {
        STATUS_READ    = 8'h01,
        CMD_FIFO_WRITE = 8'h11,
        ECHO_SEND      = 8'h20
    } opcode_e;

    // Report codes sent in the second header word
    typedef enum logic [7:0] {
        STATUS_REPORT  = 8'h81,
        ECHO_REPORT    = 8'hA0,
        CHECKSUM_ERROR = 8'hF0
    } report_e;

    // Parser position inside a packet
    typedef enum logic [3:0] {
        P_TARGET,
        P_OPCODE,
        P_ECHO_COUNT,
        P_ECHO_DATA,
        P_LEN_HI,
        P_LEN_LO,
        P_WR_DATA,
        P_CK_HI,
        P_CK_LO
    } parser_state_e;

    // Framer position inside a report
    typedef enum logic [1:0] {
        F_IDLE,
        F_HEADER,
        F_PAYLOAD,
        F_FOOTER
    } framer_state_e;

endpackage

// File: include/da_macros.svh
// ################################################
// Data-acquisition host engine widths and constants
// ################################################

`ifndef DA_MACROS_SVH
`define DA_MACROS_SVH

// Host word stream width
`define HOST_W 16

// Length field of write packets and reports
`define LEN_W 24

// Checksum and running-sum width
`define CKSUM_W 32

// Echo buffer depth in host words
`define ECHO_DEPTH 16

// Slots that accept control strobes
`define NUM_SLOTS 4

// Slot field of reports not tied to a slot
`define GLOBAL_TARGET 8'hFF

`endif
